// File: bench/io_tb.sv
module io_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int clk_freq   = 1000000;
  localparam int baud       = 125000;
  localparam int bit_cycles = clk_freq / baud;
  localparam int ack_limit  = 16;
  // ~150 bus cycles x 5, 16 bytes x 80, timer waits, then margin
  localparam int max_cycles = 20000;
  localparam logic [13:0] timer_ctrl = {4'd8, 8'd0, 2'(io_pkg::TR_CTRL)};
  // lit segments gfedcba, digits 0 to f
  localparam logic [6:0] seg_lit [16] = '{7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d,
    7'h07, 7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71};

  logic        clk_i;
  logic        rst_i;
  logic        cyc_i;
  logic        stb_i;
  logic        we_i;
  logic [3:0]  sel_i;
  logic [13:0] adr_i;
  logic [31:0] dat_i;
  logic        ack_o;
  logic [31:0] dat_o;
  logic [15:0] sw_i;
  logic [8:0]  led_o;
  logic        tx_o;
  logic [1:0]  irq_o;
  logic [6:0]  hex0_o;
  logic [6:0]  hex1_o;
  logic [6:0]  hex2_o;
  logic [6:0]  hex3_o;
  logic [6:0]  hex4_o;
  logic [6:0]  hex5_o;
  logic [6:0]  hex6_o;
  logic [6:0]  hex7_o;
  logic [55:0] hex_all;

  logic [8:0]  led_m;
  logic [31:0] seg_m;
  logic [31:0] per_m [2];
  logic [1:0]  en_m;
  logic [7:0]  exp_bytes [$];
  logic        rst_done;
  integer      seed = 32'h13fc;
  int          errors;
  int          checks;
  int          tests;
  int          rx_count;
  int          cycles;

  io_top #(.clk_freq(clk_freq), .baud(baud)) dut0 (
    .clk_i(clk_i), .rst_i(rst_i),
    .cyc_i(cyc_i), .stb_i(stb_i), .we_i(we_i), .sel_i(sel_i),
    .adr_i(adr_i), .dat_i(dat_i), .ack_o(ack_o), .dat_o(dat_o),
    .sw_i(sw_i), .led_o(led_o), .tx_o(tx_o), .irq_o(irq_o),
    .hex0_o(hex0_o), .hex1_o(hex1_o), .hex2_o(hex2_o), .hex3_o(hex3_o),
    .hex4_o(hex4_o), .hex5_o(hex5_o), .hex6_o(hex6_o), .hex7_o(hex7_o)
  );

  assign hex_all = {hex7_o, hex6_o, hex5_o, hex4_o, hex3_o, hex2_o, hex1_o, hex0_o};

  always #20 clk_i = ~clk_i;

  always @(posedge clk_i)
  begin
    cycles <= cycles + 1;
    if (cycles == max_cycles)
    begin
      $display("timeout: the run did not end within %0d cycles", max_cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  function automatic logic [55:0] seg_word(input logic [31:0] v);
    logic [55:0] w;
    for (int i = 0; i < 8; i++)
      w[i*7 +: 7] = ~seg_lit[v[i*4 +: 4]];   // active low
    return w;
  endfunction

  function automatic int ack_delay(input logic [13:0] adr);
    return (adr[13:10] == 4'd3 || adr[13:10] == 4'd8) ? 3 : 2;   // unit ack costs a cycle
  endfunction

  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    if (exp !== act)
    begin
      errors++;
      $display("FAILED at %0t ns: %s expected %0h got %0h", $time, name, exp, act);
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    tests++;
    $display("test %s finished with %0d errors", name, errors - err_before);
  endtask

  task automatic bus_access(input logic wr, input logic [13:0] adr, input logic [31:0] wdat,
                            output logic [31:0] rdat, output int n);
    @(posedge clk_i);
    cyc_i <= 1'b1;
    stb_i <= 1'b1;
    we_i  <= wr;
    sel_i <= 4'hf;
    adr_i <= adr;
    dat_i <= wdat;
    @(posedge clk_i);                      // request seen in idle here
    @(negedge clk_i);
    n = 1;
    while (!ack_o && n < ack_limit)
    begin
      @(negedge clk_i);
      n++;
    end
    if (!ack_o)
    begin
      errors++;
      $display("no ack came back for address %h at %0t ns", adr, $time);
    end
    rdat = dat_o;
    @(posedge clk_i);
    cyc_i <= 1'b0;
    stb_i <= 1'b0;
    we_i  <= 1'b0;
  endtask

  task automatic bus_write(input logic [13:0] adr, input logic [31:0] wdat);
    logic [31:0] rd;
    int n;
    bus_access(1'b1, adr, wdat, rd, n);
    check("ack_o delay", 64'(ack_delay(adr)), 64'(n));
  endtask

  task automatic bus_read(input logic [13:0] adr, output logic [31:0] rdat);
    int n;
    bus_access(1'b0, adr, 32'h0, rdat, n);
    check("ack_o delay", 64'(ack_delay(adr)), 64'(n));
  endtask

  task automatic wait_uart_idle();
    logic [31:0] r;
    int polls;
    polls = 0;
    r = 32'h1;
    while (r[0] && polls < 40)
    begin
      bus_read({4'd3, 10'd1}, r);
      polls++;
    end
    if (r[0])
    begin
      errors++;
      $display("uart still busy after %0d status reads", polls);
    end
  endtask

  task automatic leds_and_switches();
    logic [31:0] d;
    logic [31:0] r;
    int e;
    e = errors;
    for (int i = 0; i < 20; i++)
    begin
      d = $random(seed);
      led_m = d[8:0];
      bus_write({4'd2, 10'($random(seed))}, d);
      check("led_o", 64'(led_m), 64'(led_o));
      @(posedge clk_i);
      sw_i <= 16'($random(seed));
      bus_read({4'd2, 10'($random(seed))}, r);
      check("dat_o switches", 64'({16'h0, sw_i}), 64'(r));
    end
    report_test("leds and switches", e);
  endtask

  task automatic display_register();
    logic [31:0] d;
    logic [31:0] r;
    logic [13:0] a;
    int e;
    e = errors;
    @(posedge clk_i);
    sw_i <= 16'h0;
    for (int i = 0; i < 16; i++)
    begin
      d = $random(seed);
      seg_m = d;
      bus_write({4'd10, 9'($random(seed)), 1'b0}, d);
      bus_write({4'd10, 9'($random(seed)), 1'b1}, $random(seed));   // must not land
      bus_read({4'd10, 9'($random(seed)), 1'b0}, r);
      check("dat_o display", 64'(seg_m), 64'(r));
      bus_read({4'd10, 9'($random(seed)), 1'b1}, r);
      check("dat_o display offset 1", 64'(0), 64'(r));
      check("hex digits", 64'(seg_word(seg_m)), 64'(hex_all));
    end
    @(posedge clk_i);
    sw_i <= 16'h8000;                      // show the bus address
    for (int i = 0; i < 8; i++)
    begin
      a = {4'd10, 10'($random(seed))};
      bus_read(a, r);
      check("dat_o display", a[0] ? 64'(0) : 64'(seg_m), 64'(r));
      check("hex digits address", 64'(seg_word({18'h0, a})), 64'(hex_all));
    end
    @(posedge clk_i);
    sw_i <= 16'h0;
    report_test("display register", e);
  endtask

  task automatic serial_bytes();
    logic [31:0] r;
    logic [7:0] b;
    int e;
    e = errors;
    for (int i = 0; i < 16; i++)
    begin
      wait_uart_idle();
      b = 8'($random(seed));
      exp_bytes.push_back(b);
      bus_write({4'd3, 10'd0}, {24'h0, b});
      bus_read({4'd3, 10'd1}, r);
      check("uart busy", 64'(1), 64'(r));
      bus_read({4'd3, 10'd0}, r);
      check("uart data", 64'(b), 64'(r));
    end
    wait_uart_idle();
    repeat (bit_cycles) @(negedge clk_i);
    check("uart bytes left", 64'(0), 64'(exp_bytes.size()));
    check("uart bytes seen", 64'(16), 64'(rx_count));
    report_test("serial bytes", e);
  endtask

  task automatic timer_channels();
    logic [31:0] r;
    logic [13:0] per_adr;
    logic other;
    int p;
    int n;
    int e;
    e = errors;
    for (int c = 0; c < 2; c++)
    begin
      bus_write(timer_ctrl, 32'h300);      // all off, pending cleared
      en_m = 2'b00;
      p = 4 + int'($unsigned($random(seed)) % 37);
      per_m[c] = 32'(p);
      per_adr = {4'd8, 8'd0, (c == 0) ? 2'(io_pkg::TR_PERIOD0) : 2'(io_pkg::TR_PERIOD1)};
      bus_write(per_adr, per_m[c]);
      en_m = 2'(1 << c);
      bus_write(timer_ctrl, {22'h0, 2'b11, 6'h0, en_m});
      n = 0;
      other = 1'b0;
      while (!irq_o[c] && n < p + 8)
      begin
        @(negedge clk_i);
        n++;
        if (irq_o[1-c])
          other = 1'b1;
      end
      if (!irq_o[c])
      begin
        errors++;
        $display("timer channel %0d raised no interrupt within %0d cycles", c, p + 8);
      end
      check("irq_o disabled channel", 64'(0), 64'(other));
      bus_read(timer_ctrl, r);
      check("timer ctrl", 64'({en_m, 6'h0, en_m}), 64'(r));
      bus_write(timer_ctrl, 32'h0);        // stop first so no reload races the clear
      en_m = 2'b00;
      bus_write(timer_ctrl, 32'h300);
      check("irq_o after clear", 64'(0), 64'(irq_o));
      bus_read(per_adr, r);
      check("timer period", 64'(per_m[c]), 64'(r));
    end
    repeat (60) @(negedge clk_i);
    check("irq_o idle", 64'(0), 64'(irq_o));
    bus_read(timer_ctrl, r);
    check("timer ctrl idle", 64'(0), 64'(r));
    report_test("timer channels", e);
  endtask

  task automatic unmapped_units();
    logic [31:0] r;
    logic [3:0] code;
    int e;
    e = errors;
    @(posedge clk_i);
    sw_i <= 16'($random(seed)) | 16'h1;    // switch reads leave a nonzero result
    for (int i = 0; i < 8; i++)
    begin
      bus_read({4'd2, 10'($random(seed))}, r);
      check("dat_o switches", 64'({16'h0, sw_i}), 64'(r));
      code = 4'($random(seed));
      while (code == 4'd2 || code == 4'd3 || code == 4'd8 || code == 4'd10)
        code = 4'($random(seed));
      bus_read({code, 10'($random(seed))}, r);
      check("dat_o unmapped", 64'(0), 64'(r));
    end
    report_test("unmapped units", e);
  endtask

  // rebuilds each frame from mid-bit samples of tx_o
  initial
  begin
    logic [7:0] rx;
    wait (rst_done);
    forever
    begin
      @(negedge tx_o);
      repeat (bit_cycles / 2) @(negedge clk_i);
      check("tx_o start bit", 64'(0), 64'(tx_o));
      for (int i = 0; i < 8; i++)
      begin
        repeat (bit_cycles) @(negedge clk_i);
        rx[i] = tx_o;                      // lsb first
      end
      repeat (bit_cycles) @(negedge clk_i);
      check("tx_o stop bit", 64'(1), 64'(tx_o));
      if (exp_bytes.size() == 0)
      begin
        errors++;
        $display("serial byte %h arrived with no byte expected", rx);
      end
      else
        check("tx_o byte", 64'(exp_bytes.pop_front()), 64'(rx));
      rx_count++;
    end
  end

  initial
  begin
    clk_i    = 1'b0;
    rst_i    = 1'b1;
    cyc_i    = 1'b0;
    stb_i    = 1'b0;
    we_i     = 1'b0;
    sel_i    = 4'h0;
    adr_i    = 14'h0;
    dat_i    = 32'h0;
    sw_i     = 16'h0;
    rst_done = 1'b0;
    errors   = 0;
    checks   = 0;
    tests    = 0;
    rx_count = 0;
    cycles   = 0;
    repeat (4) @(posedge clk_i);
    rst_i <= 1'b0;
    @(negedge clk_i);
    rst_done = 1'b1;
    check("ack_o after reset", 64'(0), 64'(ack_o));
    check("led_o after reset", 64'(0), 64'(led_o));
    check("tx_o after reset", 64'(1), 64'(tx_o));
    check("irq_o after reset", 64'(0), 64'(irq_o));
    check("hex digits after reset", 64'(seg_word(32'h0)), 64'(hex_all));
    leds_and_switches();
    display_register();
    serial_bytes();
    timer_channels();
    unmapped_units();
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

// File: flist.f
verilog/io_pkg.sv
verilog/io_controller.sv
verilog/io_timer.sv
verilog/uart_tx.sv
verilog/seg_display.sv
verilog/io_top.sv
bench/io_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert -f flist.f --top-module io_tb \
  -Mdir obj_dir -o io_sim > build.log 2>&1 \
  && ./obj_dir/io_sim > sim.log 2>&1 \
  || echo "build or run error, see build.log and sim.log"
grep -qs "Simulation completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: verilog/io_controller.sv
module io_controller (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      cyc_i,
  input  logic                      stb_i,
  input  logic                      we_i,
  input  logic [io_pkg::adr_w-1:0]  adr_i,
  input  logic [io_pkg::data_w-1:0] dat_i,
  input  logic [15:0]               sw_i,
  input  logic [io_pkg::data_w-1:0] uart_dat_i,
  input  logic                      uart_ack_i,
  input  logic [io_pkg::data_w-1:0] timer_dat_i,
  input  logic                      timer_ack_i,
  output logic                      uart_stb_o,
  output logic                      timer_stb_o,
  output logic                      ack_o,
  output logic [io_pkg::data_w-1:0] dat_o,
  output logic [8:0]                led_o,
  output logic [io_pkg::data_w-1:0] seg_reg_o
);

  io_pkg::state_t            state_q;
  io_pkg::state_t            state_d;
  logic [io_pkg::data_w-1:0] result_q;
  logic [io_pkg::data_w-1:0] result_d;
  logic [io_pkg::data_w-1:0] seg_d;
  logic [8:0]                led_d;
  logic                      miss_q;
  logic                      miss_d;
  logic [4:0]                code;

  assign code        = {1'b0, adr_i[13:10]};
  assign ack_o       = (state_q == io_pkg::S_DONE);
  assign dat_o       = result_q;
  assign uart_stb_o  = (state_q == io_pkg::S_UART);
  assign timer_stb_o = (state_q == io_pkg::S_TIMER);

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      state_q   <= io_pkg::S_IDLE;
      miss_q    <= 1'b0;
      led_o     <= '0;
      seg_reg_o <= '0;
    end
    else
    begin
      state_q   <= state_d;
      miss_q    <= miss_d;
      led_o     <= led_d;
      seg_reg_o <= seg_d;
    end
  end

  always_ff @(posedge clk_i)
  begin
    result_q <= result_d;
  end

  always_comb
  begin
    state_d  = state_q;
    result_d = result_q;
    led_d    = led_o;
    seg_d    = seg_reg_o;
    miss_d   = miss_q;
    case (state_q)
      io_pkg::S_IDLE:
        if (miss_q)
        begin
          miss_d  = 1'b0;                // unmapped code, spend the decode cycle
          state_d = io_pkg::S_DONE;
        end
        else if (cyc_i && stb_i)
        begin
          case (code)
            io_pkg::S_SWLED, io_pkg::S_UART, io_pkg::S_TIMER, io_pkg::S_SEGFAN:
              state_d = io_pkg::state_t'(code);
            default:
            begin
              miss_d   = 1'b1;
              result_d = '0;
            end
          endcase
        end
      io_pkg::S_SWLED:
      begin
        if (we_i)
          led_d = dat_i[8:0];
        else
          result_d = {{(io_pkg::data_w-16){1'b0}}, sw_i};
        state_d = io_pkg::S_DONE;
      end
      io_pkg::S_SEGFAN:
      begin
        if (we_i)
        begin
          if (!adr_i[0])
            seg_d = dat_i;               // offset 1 is read-as-zero
        end
        else
          result_d = adr_i[0] ? '0 : seg_reg_o;
        state_d = io_pkg::S_DONE;
      end
      io_pkg::S_UART:
        if (uart_ack_i)
        begin
          if (!we_i)
            result_d = uart_dat_i;
          state_d = io_pkg::S_DONE;
        end
      io_pkg::S_TIMER:
        if (timer_ack_i)
        begin
          if (!we_i)
            result_d = timer_dat_i;
          state_d = io_pkg::S_DONE;
        end
      io_pkg::S_DONE:
        state_d = io_pkg::S_IDLE;
      default:
        state_d = io_pkg::S_IDLE;
    endcase
  end

  // a single-cycle ack, then back through idle
  ack_single: assert property (@(posedge clk_i) disable iff (rst_i)
    ack_o |=> !ack_o);

  state_legal: assert property (@(posedge clk_i) disable iff (rst_i)
    state_q inside {io_pkg::S_IDLE, io_pkg::S_DONE, io_pkg::S_SWLED,
                    io_pkg::S_UART, io_pkg::S_TIMER, io_pkg::S_SEGFAN});

endmodule

// File: verilog/io_pkg.sv
package io_pkg;

  parameter int data_w = 32;     // bus data width
  parameter int adr_w  = 14;     // word address width

  // adr[13:10] selects the unit and doubles as the state number
  typedef enum logic [4:0] {
    S_IDLE   = 5'd0,
    S_DONE   = 5'd1,
    S_SWLED  = 5'd2,
    S_UART   = 5'd3,
    S_TIMER  = 5'd8,
    S_SEGFAN = 5'd10
  } state_t;

  typedef enum logic [1:0] {
    TR_COUNT0  = 2'd0,           // channel 0 count, read only
    TR_PERIOD0 = 2'd1,
    TR_PERIOD1 = 2'd2,
    TR_CTRL    = 2'd3            // enables [1:0], pending [9:8]
  } timer_reg_t;

endpackage

// File: verilog/io_timer.sv
module io_timer (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      stb_i,
  input  logic                      we_i,
  input  logic [1:0]                adr_i,
  input  logic [io_pkg::data_w-1:0] dat_i,
  output logic [io_pkg::data_w-1:0] dat_o,
  output logic                      ack_o,
  output logic [1:0]                irq_o
);

  logic [io_pkg::data_w-1:0] cnt_q [2];
  logic [io_pkg::data_w-1:0] per_q [2];
  logic [1:0]                en_q;
  logic [1:0]                pend_q;
  logic [1:0]                hit;
  logic                      access;
  io_pkg::timer_reg_t        reg_sel;

  assign access  = stb_i && !ack_o;      // strobe stays up through the ack
  assign reg_sel = io_pkg::timer_reg_t'(adr_i);
  assign irq_o   = pend_q;

  always_comb
  begin
    for (int i = 0; i < 2; i++)
      hit[i] = en_q[i] && (cnt_q[i] == '0);
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      ack_o  <= 1'b0;
      en_q   <= '0;
      pend_q <= '0;
      for (int i = 0; i < 2; i++)
      begin
        cnt_q[i] <= '0;
        per_q[i] <= '0;
      end
    end
    else
    begin
      ack_o <= access;
      for (int i = 0; i < 2; i++)
      begin
        if (hit[i])
          cnt_q[i] <= per_q[i];          // reload
        else if (en_q[i])
          cnt_q[i] <= cnt_q[i] - 1'b1;
      end
      pend_q <= pend_q | hit;
      if (access && we_i)
      begin
        case (reg_sel)
          io_pkg::TR_PERIOD0:
          begin
            per_q[0] <= dat_i;
            cnt_q[0] <= dat_i;
          end
          io_pkg::TR_PERIOD1:
          begin
            per_q[1] <= dat_i;
            cnt_q[1] <= dat_i;
          end
          io_pkg::TR_CTRL:
          begin
            en_q   <= dat_i[1:0];
            pend_q <= (pend_q & ~dat_i[9:8]) | hit;   // new expiry beats the clear
          end
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (access)
    begin
      case (reg_sel)
        io_pkg::TR_COUNT0:  dat_o <= cnt_q[0];
        io_pkg::TR_PERIOD0: dat_o <= per_q[0];
        io_pkg::TR_PERIOD1: dat_o <= per_q[1];
        default:            dat_o <= {{(io_pkg::data_w-10){1'b0}}, pend_q, 6'b0, en_q};
      endcase
    end
  end

  for (genvar i = 0; i < 2; i++)
  begin : g_chk
    pend_at_zero: assert property (@(posedge clk_i) disable iff (rst_i)
      $rose(pend_q[i]) |-> $past(cnt_q[i] == '0));
  end

endmodule

// File: verilog/io_top.sv
module io_top #(
  parameter int clk_freq = 1000000,
  parameter int baud     = 115200
) (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      cyc_i,
  input  logic                      stb_i,
  input  logic                      we_i,
  input  logic [3:0]                sel_i,
  input  logic [io_pkg::adr_w-1:0]  adr_i,
  input  logic [io_pkg::data_w-1:0] dat_i,
  output logic                      ack_o,
  output logic [io_pkg::data_w-1:0] dat_o,
  input  logic [15:0]               sw_i,
  output logic [8:0]                led_o,
  output logic                      tx_o,
  output logic [1:0]                irq_o,
  output logic [6:0]                hex0_o,
  output logic [6:0]                hex1_o,
  output logic [6:0]                hex2_o,
  output logic [6:0]                hex3_o,
  output logic [6:0]                hex4_o,
  output logic [6:0]                hex5_o,
  output logic [6:0]                hex6_o,
  output logic [6:0]                hex7_o
);

  logic [io_pkg::data_w-1:0] uart_dat;
  logic [io_pkg::data_w-1:0] timer_dat;
  logic [io_pkg::data_w-1:0] seg_reg;
  logic                      uart_ack;
  logic                      timer_ack;
  logic                      uart_stb;
  logic                      timer_stb;

  io_controller ctrl0 (
    .clk_i(clk_i), .rst_i(rst_i),
    .cyc_i(cyc_i), .stb_i(stb_i), .we_i(we_i),
    .adr_i(adr_i), .dat_i(dat_i), .sw_i(sw_i),
    .uart_dat_i(uart_dat), .uart_ack_i(uart_ack),
    .timer_dat_i(timer_dat), .timer_ack_i(timer_ack),
    .uart_stb_o(uart_stb), .timer_stb_o(timer_stb),
    .ack_o(ack_o), .dat_o(dat_o),
    .led_o(led_o), .seg_reg_o(seg_reg)
  );

  io_timer timer0 (
    .clk_i(clk_i), .rst_i(rst_i),
    .stb_i(timer_stb), .we_i(we_i), .adr_i(adr_i[1:0]),
    .dat_i(dat_i), .dat_o(timer_dat), .ack_o(timer_ack),
    .irq_o(irq_o)
  );

  uart_tx #(.clk_freq(clk_freq), .baud(baud)) uart0 (
    .clk_i(clk_i), .rst_i(rst_i),
    .stb_i(uart_stb), .we_i(we_i), .adr_i(adr_i[0]),
    .dat_i(dat_i), .dat_o(uart_dat), .ack_o(uart_ack),
    .tx_o(tx_o)
  );

  seg_display seg0 (
    .seg_reg_i(seg_reg), .adr_i(adr_i), .sel_adr_i(sw_i[15]),   // sw15 shows the address
    .hex0_o(hex0_o), .hex1_o(hex1_o), .hex2_o(hex2_o), .hex3_o(hex3_o),
    .hex4_o(hex4_o), .hex5_o(hex5_o), .hex6_o(hex6_o), .hex7_o(hex7_o)
  );

  // master keeps the request steady until it sees ack
  bus_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    cyc_i && stb_i && !ack_o |=> stb_i && $stable({we_i, sel_i, adr_i, dat_i}));

endmodule

// File: verilog/seg_display.sv
module seg_display (
  input  logic [io_pkg::data_w-1:0] seg_reg_i,
  input  logic [io_pkg::adr_w-1:0]  adr_i,
  input  logic                      sel_adr_i,
  output logic [6:0]                hex0_o,
  output logic [6:0]                hex1_o,
  output logic [6:0]                hex2_o,
  output logic [6:0]                hex3_o,
  output logic [6:0]                hex4_o,
  output logic [6:0]                hex5_o,
  output logic [6:0]                hex6_o,
  output logic [6:0]                hex7_o
);

  logic [io_pkg::data_w-1:0] src;

  // active low, {g,f,e,d,c,b,a}
  function automatic logic [6:0] hex_seg(input logic [3:0] nib);
    case (nib)
      4'h0: return 7'h40;
      4'h1: return 7'h79;
      4'h2: return 7'h24;
      4'h3: return 7'h30;
      4'h4: return 7'h19;
      4'h5: return 7'h12;
      4'h6: return 7'h02;
      4'h7: return 7'h78;
      4'h8: return 7'h00;
      4'h9: return 7'h10;
      4'ha: return 7'h08;
      4'hb: return 7'h03;
      4'hc: return 7'h46;
      4'hd: return 7'h21;
      4'he: return 7'h06;
      default: return 7'h0e;
    endcase
  endfunction

  assign src = sel_adr_i ? {{(io_pkg::data_w-io_pkg::adr_w){1'b0}}, adr_i} : seg_reg_i;

  assign hex0_o = hex_seg(src[3:0]);
  assign hex1_o = hex_seg(src[7:4]);
  assign hex2_o = hex_seg(src[11:8]);
  assign hex3_o = hex_seg(src[15:12]);
  assign hex4_o = hex_seg(src[19:16]);
  assign hex5_o = hex_seg(src[23:20]);
  assign hex6_o = hex_seg(src[27:24]);
  assign hex7_o = hex_seg(src[31:28]);

endmodule

// File: verilog/uart_tx.sv
module uart_tx #(
  parameter int clk_freq = 1000000,
  parameter int baud     = 115200
) (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      stb_i,
  input  logic                      we_i,
  input  logic                      adr_i,
  input  logic [io_pkg::data_w-1:0] dat_i,
  output logic [io_pkg::data_w-1:0] dat_o,
  output logic                      ack_o,
  output logic                      tx_o
);

  localparam int bit_cycles = clk_freq / baud;
  localparam int cnt_w      = (bit_cycles > 1) ? $clog2(bit_cycles) : 1;

  typedef enum logic [1:0] {U_IDLE, U_START, U_DATA, U_STOP} tx_state_t;

  tx_state_t        state_q;
  logic [cnt_w-1:0] tick_q;
  logic [2:0]       bit_q;
  logic [7:0]       shift_q;
  logic [7:0]       byte_q;
  logic             access;
  logic             busy;
  logic             load;
  logic             bit_end;

  assign access  = stb_i && !ack_o;
  assign busy    = (state_q != U_IDLE);
  assign load    = access && we_i && !adr_i && !busy;   // dropped while busy
  assign bit_end = (tick_q == cnt_w'(bit_cycles - 1));

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      state_q <= U_IDLE;
      tick_q  <= '0;
      bit_q   <= '0;
      tx_o    <= 1'b1;
      ack_o   <= 1'b0;
    end
    else
    begin
      ack_o  <= access;
      tick_q <= (state_q == U_IDLE || bit_end) ? '0 : tick_q + 1'b1;
      case (state_q)
        U_IDLE:
          if (load)
          begin
            state_q <= U_START;
            tx_o    <= 1'b0;
          end
        U_START:
          if (bit_end)
          begin
            state_q <= U_DATA;
            tx_o    <= shift_q[0];       // lsb first
            bit_q   <= '0;
          end
        U_DATA:
          if (bit_end)
          begin
            if (bit_q == 3'd7)
            begin
              state_q <= U_STOP;
              tx_o    <= 1'b1;
            end
            else
            begin
              tx_o  <= shift_q[1];
              bit_q <= bit_q + 1'b1;
            end
          end
        default:
          if (bit_end)
            state_q <= U_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (load)
    begin
      shift_q <= dat_i[7:0];
      byte_q  <= dat_i[7:0];
    end
    else if (state_q == U_DATA && bit_end)
      shift_q <= shift_q >> 1;
    if (access)
      dat_o <= adr_i ? {{(io_pkg::data_w-1){1'b0}}, busy}
                     : {{(io_pkg::data_w-8){1'b0}}, byte_q};
  end

  idle_line_high: assert property (@(posedge clk_i) disable iff (rst_i)
    state_q == U_IDLE |-> tx_o);

endmodule
